// File: ssm_block.f
+incdir+.
ssm_num_pkg.sv
ssm_flow_pkg.sv
ssm_elem_if.sv
ssm_operand_sequencer.sv
ssm_state_update.sv
ssm_output_accum.sv
ssm_block_top.sv
tb_ssm_checker.sv
tb_ssm_block.sv

// File: ssm_block_stimulus.txt
// per case: dt[2] da[2] d[2] / b[4] c[4] / x[4] / h_prev[16] / y[4] / h_next[16]
// q8.8 words in hex, lowest flat index first, last two lines are expected values
// case 0: mixed signs, floor rounding on odd products
0080 0040 00C0 00E0 0100 FF80
0100 0080 FF00 0200 0100 FF80 0040 0080
0200 FF00 0100 0300
0100 FE00 0064 FFFD 0000 03E8 FFB3 0032 0200 0005 FF00 0400 FF9C 012C 0007 FD80
0510 FCCC 0326 FDAE
01C0 FF00 FF4B 01FD FF80 02AE 0046 FF25 0200 0024 FEE0 0400 0068 0166 FF46 FF50
// case 1: zero h_prev, h_next is dt*x*b
0033 00A0 0080 0100 0020 0180
0100 FF40 0055 0010 0080 0100 FF00 0300
0100 FE80 0066 0400
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
000B FFED 007D 0504
0033 FFD9 0010 0003 FFB3 0039 FFE6 FFFB 003F FFD0 0014 0003 0280 FE20 00D4 0028
// case 2: da = 1.0, dt = 0, h_next equals h_prev, b has no effect
0000 0000 0100 0100 0200 FF00
1234 7FFF 8000 0001 0040 0080 00C0 0100
0010 FFF0 0100 0001
0100 0200 0300 0400 FF00 0080 FFFF 0011 0005 000A FFFB 0020 1000 F000 0800 0000
07A0 FFF0 FF22 01FF
0100 0200 0300 0400 FF00 0080 FFFF 0011 0005 000A FFFB 0020 1000 F000 0800 0000
// case 3: large operands, products and sums clamp to 7fff / 8000
7FFF 0100 7FFF 8000 7FFF 0100
0100 7FFF 0000 FF00 0100 0200 8000 0001
7FFF 8000 0200 FF00
7000 0000 8000 0100 8000 7FFF 0000 C000 0100 FF00 0001 0000 0080 0000 7FFF 8000
7FFF 8000 43FD FF7E
7FFF 7FFF 8000 0000 8000 FFFF 0000 FFFF 8200 7FFF FF80 FE00 BF00 8001 8000 7FFF

// File: ssm_block_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ssm_defs.svh"

module ssm_block_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [`SSM_H*`SSM_DW-1:0]              dt_flat,
    input  logic [`SSM_H*`SSM_DW-1:0]              da_flat,
    input  logic [`SSM_N*`SSM_DW-1:0]              b_flat,
    input  logic [`SSM_N*`SSM_DW-1:0]              c_flat,
    input  logic [`SSM_H*`SSM_DW-1:0]              d_flat,
    input  logic [`SSM_H*`SSM_P*`SSM_DW-1:0]       x_flat,
    input  logic [`SSM_H*`SSM_P*`SSM_N*`SSM_DW-1:0] h_prev_flat,
    output logic [`SSM_H*`SSM_P*`SSM_DW-1:0]       y_flat,
    output logic [`SSM_H*`SSM_P*`SSM_N*`SSM_DW-1:0] h_next_flat,
    output logic                                   done
);
    import ssm_flow_pkg::*;

    // d held by the sequencer for the skip path
    logic [`SSM_H*`SSM_DW-1:0] d_latched;

    // ============================================================
    // element streams
    // ============================================================

    ssm_elem_if #(.payload_t(operand_t)) op_bus ();
    ssm_elem_if #(.payload_t(term_t))    term_bus ();

    // ============================================================
    // sequencer -> update pipe -> accumulator
    // ============================================================

    ssm_operand_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .dt_flat     (dt_flat),
        .da_flat     (da_flat),
        .b_flat      (b_flat),
        .c_flat      (c_flat),
        .d_flat      (d_flat),
        .x_flat      (x_flat),
        .h_prev_flat (h_prev_flat),
        .d_latched   (d_latched),
        .ops         (op_bus.src)
    );

    // 3-cycle pipe, also holds the next state
    ssm_state_update u_upd (
        .clk         (clk),
        .rst         (rst),
        .ops         (op_bus.dst),
        .terms       (term_bus.src),
        .h_next_flat (h_next_flat)
    );

    ssm_output_accum u_acc (
        .clk       (clk),
        .rst       (rst),
        .terms     (term_bus.dst),
        .d_latched (d_latched),
        .y_flat    (y_flat),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: ssm_defs.svh
`ifndef SSM_DEFS_SVH
`define SSM_DEFS_SVH

// ============================================================
// block geometry
// ============================================================

// heads per step
`define SSM_H    2
// channels per head
`define SSM_P    2
// state entries per channel
`define SSM_N    4

// ============================================================
// number format
// ============================================================

// signed q8.8 word
`define SSM_DW   16
`define SSM_FRAC 8

// width of one h, p or n index field
`define SSM_IW   2

`endif

// File: ssm_elem_if.sv
`timescale 1ns/1ps
`default_nettype none

// one element per cycle, no back-pressure
interface ssm_elem_if #(
    parameter type payload_t = logic
);
    import ssm_flow_pkg::*;

    logic      valid;
    elem_idx_t idx;
    payload_t  data;
    // one-cycle pulse at step start
    logic      clear;

    // sender side drives everything
    modport src (
        output valid,
        output idx,
        output data,
        output clear
    );

    modport dst (
        input valid,
        input idx,
        input data,
        input clear
    );

endinterface

`default_nettype wire

// File: ssm_flow_pkg.sv
`default_nettype none

`include "ssm_defs.svh"

package ssm_flow_pkg;
    import ssm_num_pkg::*;

    // position of one element in the step, plus end markers
    typedef struct packed {
        logic [`SSM_IW-1:0] h;
        logic [`SSM_IW-1:0] p;
        logic [`SSM_IW-1:0] n;
        logic               last_n;     // n == N-1
        logic               last_elem;  // final element of the step
    } elem_idx_t;

    // everything the update pipe needs for one (h,p,n)
    typedef struct packed {
        elem_idx_t idx;
        q_t        da;
        q_t        dt;
        q_t        x;
        q_t        b;
        q_t        c;
        q_t        h_prev;
    } operand_t;

    // c-weighted state term, x rides along for the skip path
    typedef struct packed {
        elem_idx_t idx;
        q_t        hc;
        q_t        x;
    } term_t;

endpackage

`default_nettype wire

// File: ssm_num_pkg.sv
`default_nettype none

`include "ssm_defs.svh"

package ssm_num_pkg;

    // signed fixed-point word
    typedef logic signed [`SSM_DW-1:0] q_t;

    // saturation bounds as plain integers
    localparam int Q_MAX_I = (1 << (`SSM_DW - 1)) - 1;
    localparam int Q_MIN_I = -(1 << (`SSM_DW - 1));

    // ============================================================
    // q-format multiply
    // ============================================================

    // full product, arithmetic shift (floor), clamp to one word
    function automatic q_t q_mul(input q_t a, input q_t b);
        logic signed [2*`SSM_DW-1:0] prod;
        logic signed [2*`SSM_DW-1:0] shr;
        prod = a * b;
        shr  = prod >>> `SSM_FRAC;
        if (shr > Q_MAX_I)
            return q_t'(Q_MAX_I);
        else if (shr < Q_MIN_I)
            return q_t'(Q_MIN_I);
        return shr[`SSM_DW-1:0];
    endfunction

    // ============================================================
    // saturating add
    // ============================================================

    function automatic q_t q_add(input q_t a, input q_t b);
        logic signed [`SSM_DW:0] sum;
        sum = a + b;
        // overflow when the two top bits disagree
        if (sum[`SSM_DW] != sum[`SSM_DW-1])
            return sum[`SSM_DW] ? q_t'(Q_MIN_I) : q_t'(Q_MAX_I);
        return sum[`SSM_DW-1:0];
    endfunction

endpackage

`default_nettype wire

// File: ssm_operand_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ssm_defs.svh"

module ssm_operand_sequencer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [`SSM_H*`SSM_DW-1:0]              dt_flat,
    input  logic [`SSM_H*`SSM_DW-1:0]              da_flat,
    input  logic [`SSM_N*`SSM_DW-1:0]              b_flat,
    input  logic [`SSM_N*`SSM_DW-1:0]              c_flat,
    input  logic [`SSM_H*`SSM_DW-1:0]              d_flat,
    input  logic [`SSM_H*`SSM_P*`SSM_DW-1:0]       x_flat,
    input  logic [`SSM_H*`SSM_P*`SSM_N*`SSM_DW-1:0] h_prev_flat,
    output logic [`SSM_H*`SSM_DW-1:0]              d_latched,
    ssm_elem_if.src                                ops
);
    import ssm_num_pkg::*;
    import ssm_flow_pkg::*;

    // latched copies of the step inputs
    logic [`SSM_H*`SSM_DW-1:0]               dt_q;
    logic [`SSM_H*`SSM_DW-1:0]               da_q;
    logic [`SSM_N*`SSM_DW-1:0]               b_q;
    logic [`SSM_N*`SSM_DW-1:0]               c_q;
    logic [`SSM_H*`SSM_P*`SSM_DW-1:0]        x_q;
    logic [`SSM_H*`SSM_P*`SSM_N*`SSM_DW-1:0] h_prev_q;

    logic                busy;     // step in progress
    logic                arm;      // one cycle between accept and clear
    logic                issuing;  // counters walking
    logic                accept;
    logic [`SSM_IW-1:0]  h_cnt;
    logic [`SSM_IW-1:0]  p_cnt;
    logic [`SSM_IW-1:0]  n_cnt;
    logic                p_last;
    logic                h_last;
    elem_idx_t           cur_idx;
    operand_t            cur_op;

    assign accept = start && !busy;
    assign p_last = (p_cnt == `SSM_P - 1);
    assign h_last = (h_cnt == `SSM_H - 1);

    // ============================================================
    // operand select for the current (h,p,n)
    // ============================================================

    always_comb begin
        cur_idx.h         = h_cnt;
        cur_idx.p         = p_cnt;
        cur_idx.n         = n_cnt;
        cur_idx.last_n    = (n_cnt == `SSM_N - 1);
        cur_idx.last_elem = cur_idx.last_n && p_last && h_last;

        cur_op.idx    = cur_idx;
        // per-head words
        cur_op.da     = da_q[int'(h_cnt)*`SSM_DW +: `SSM_DW];
        cur_op.dt     = dt_q[int'(h_cnt)*`SSM_DW +: `SSM_DW];
        // per-channel word
        cur_op.x      = x_q[(int'(h_cnt)*`SSM_P + int'(p_cnt))*`SSM_DW +: `SSM_DW];
        // shared over heads, indexed by n only
        cur_op.b      = b_q[int'(n_cnt)*`SSM_DW +: `SSM_DW];
        cur_op.c      = c_q[int'(n_cnt)*`SSM_DW +: `SSM_DW];
        cur_op.h_prev = h_prev_q[((int'(h_cnt)*`SSM_P + int'(p_cnt))*`SSM_N
                                 + int'(n_cnt))*`SSM_DW +: `SSM_DW];
    end

    // ============================================================
    // step control, n fastest then p then h
    // ============================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            arm       <= 1'b0;
            issuing   <= 1'b0;
            h_cnt     <= '0;
            p_cnt     <= '0;
            n_cnt     <= '0;
            ops.valid <= 1'b0;
            ops.clear <= 1'b0;
        end else begin
            ops.clear <= arm;
            ops.valid <= issuing;
            arm       <= accept;
            if (accept)
                busy <= 1'b1;
            // clear goes out now, first element next cycle
            if (arm)
                issuing <= 1'b1;
            if (issuing) begin
                n_cnt <= cur_idx.last_n ? '0 : n_cnt + 1'b1;
                if (cur_idx.last_n)
                    p_cnt <= p_last ? '0 : p_cnt + 1'b1;
                if (cur_idx.last_n && p_last)
                    h_cnt <= h_last ? '0 : h_cnt + 1'b1;
                // counters are back at zero for the next step
                if (cur_idx.last_elem) begin
                    issuing <= 1'b0;
                    busy    <= 1'b0;
                end
            end
        end
    end

    // input latch and outgoing payload
    always_ff @(posedge clk) begin
        if (accept) begin
            dt_q      <= dt_flat;
            da_q      <= da_flat;
            b_q       <= b_flat;
            c_q       <= c_flat;
            d_latched <= d_flat;
            x_q       <= x_flat;
            h_prev_q  <= h_prev_flat;
        end
        if (issuing) begin
            ops.idx  <= cur_idx;
            ops.data <= cur_op;
        end
    end

endmodule

`default_nettype wire

// File: ssm_output_accum.sv
`timescale 1ns/1ps
`default_nettype none

`include "ssm_defs.svh"

module ssm_output_accum (
    input  logic                             clk,
    input  logic                             rst,
    ssm_elem_if.dst                          terms,
    input  logic [`SSM_H*`SSM_DW-1:0]        d_latched,
    output logic [`SSM_H*`SSM_P*`SSM_DW-1:0] y_flat,
    output logic                             done
);
    import ssm_num_pkg::*;
    import ssm_flow_pkg::*;

    localparam int HP_W = $clog2(`SSM_H * `SSM_P);

    q_t            acc_sum;  // running sum over n
    q_t            sum_nxt;
    q_t            d_word;
    q_t            dx_term;
    q_t            y_word;
    logic [HP_W-1:0] y_slot;
    logic          last_q;   // last element seen last cycle

    // ============================================================
    // sum over n plus skip term
    // ============================================================

    always_comb begin
        // n == 0 restarts the sum
        if (terms.idx.n == '0)
            sum_nxt = terms.data.hc;
        else
            sum_nxt = q_add(acc_sum, terms.data.hc);

        // skip path d[h]*x
        d_word  = d_latched[int'(terms.idx.h)*`SSM_DW +: `SSM_DW];
        dx_term = q_mul(d_word, terms.data.x);
        y_word  = q_add(sum_nxt, dx_term);

        // output word for (h,p)
        y_slot = HP_W'(int'(terms.data.idx.h)*`SSM_P + int'(terms.data.idx.p));
    end

    always_ff @(posedge clk) begin
        if (terms.valid)
            acc_sum <= sum_nxt;
    end

    // ============================================================
    // y store
    // ============================================================

    // written one cycle after the last_n term
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            y_flat <= '0;
        end else if (terms.clear) begin
            y_flat <= '0;
        end else if (terms.valid && terms.idx.last_n) begin
            y_flat[int'(y_slot)*`SSM_DW +: `SSM_DW] <= y_word;
        end
    end

    // ============================================================
    // done pulse
    // ============================================================

    // two cycles after the final term, one cycle wide
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            last_q <= terms.valid && terms.idx.last_elem;
            done   <= last_q;
        end
    end

endmodule

`default_nettype wire

// File: ssm_state_update.sv
`timescale 1ns/1ps
`default_nettype none

`include "ssm_defs.svh"

module ssm_state_update (
    input  logic                                   clk,
    input  logic                                   rst,
    ssm_elem_if.dst                                ops,
    ssm_elem_if.src                                terms,
    output logic [`SSM_H*`SSM_P*`SSM_N*`SSM_DW-1:0] h_next_flat
);
    import ssm_num_pkg::*;
    import ssm_flow_pkg::*;

    localparam int NUM_ELEM = `SSM_H * `SSM_P * `SSM_N;
    localparam int SLOT_W   = $clog2(NUM_ELEM);

    // flat slot of the incoming element
    logic [SLOT_W-1:0] op_slot;

    // stage 1: da*h_prev and dt*x
    logic              s1_valid;
    logic              s1_clear;
    elem_idx_t         s1_idx;
    logic [SLOT_W-1:0] s1_slot;
    q_t                s1_ah;
    q_t                s1_dx;
    q_t                s1_b;
    q_t                s1_c;
    q_t                s1_x;

    // stage 2: h_next
    logic              s2_valid;
    logic              s2_clear;
    elem_idx_t         s2_idx;
    logic [SLOT_W-1:0] s2_slot;
    q_t                s2_hn;
    q_t                s2_c;
    q_t                s2_x;

    assign op_slot = SLOT_W'((int'(ops.data.idx.h)*`SSM_P + int'(ops.data.idx.p))*`SSM_N
                             + int'(ops.data.idx.n));

    // ============================================================
    // valid and clear travel with the data, 3 stages
    // ============================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            s1_clear    <= 1'b0;
            s2_valid    <= 1'b0;
            s2_clear    <= 1'b0;
            terms.valid <= 1'b0;
            terms.clear <= 1'b0;
        end else begin
            s1_valid    <= ops.valid;
            s1_clear    <= ops.clear;
            s2_valid    <= s1_valid;
            s2_clear    <= s1_clear;
            terms.valid <= s2_valid;
            terms.clear <= s2_clear;
        end
    end

    // ============================================================
    // datapath
    // ============================================================

    always_ff @(posedge clk) begin
        // stage 1
        s1_idx  <= ops.idx;
        s1_slot <= op_slot;
        s1_ah   <= q_mul(ops.data.da, ops.data.h_prev);
        s1_dx   <= q_mul(ops.data.dt, ops.data.x);
        s1_b    <= ops.data.b;
        s1_c    <= ops.data.c;
        s1_x    <= ops.data.x;

        // stage 2, (dt*x)*b onto the decayed state
        s2_idx  <= s1_idx;
        s2_slot <= s1_slot;
        s2_hn   <= q_add(s1_ah, q_mul(s1_dx, s1_b));
        s2_c    <= s1_c;
        s2_x    <= s1_x;

        // stage 3, weight by c
        terms.idx      <= s2_idx;
        terms.data.idx <= s2_idx;
        terms.data.hc  <= q_mul(s2_hn, s2_c);
        terms.data.x   <= s2_x;
    end

    // state store, written on the edge the term leaves
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_next_flat <= '0;
        end else if (ops.clear) begin
            h_next_flat <= '0;
        end else if (s2_valid) begin
            h_next_flat[int'(s2_slot)*`SSM_DW +: `SSM_DW] <= s2_hn;
        end
    end

endmodule

`default_nettype wire

// File: tb_ssm_block.sv
`timescale 1ns/1ps
`default_nettype none

`include "ssm_defs.svh"

module tb_ssm_block;
    import ssm_num_pkg::*;

    localparam int NUM_Y     = `SSM_H * `SSM_P;
    localparam int NUM_ELEM  = `SSM_H * `SSM_P * `SSM_N;
    localparam int NUM_CASES = 4;
    // record layout in the stimulus file, in words
    localparam int OFF_DT    = 0;
    localparam int OFF_DA    = OFF_DT + `SSM_H;
    localparam int OFF_D     = OFF_DA + `SSM_H;
    localparam int OFF_B     = OFF_D + `SSM_H;
    localparam int OFF_C     = OFF_B + `SSM_N;
    localparam int OFF_X     = OFF_C + `SSM_N;
    localparam int OFF_HP    = OFF_X + NUM_Y;
    localparam int OFF_Y     = OFF_HP + NUM_ELEM;
    localparam int OFF_HN    = OFF_Y + NUM_Y;
    localparam int REC_WORDS = OFF_HN + NUM_ELEM;
    localparam int TIMEOUT_CYCLES = NUM_CASES * (NUM_ELEM + 20) + 50;
    // case that sees a stray start mid-step
    localparam int POKE_CASE = 2;

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            start;
    logic [`SSM_H*`SSM_DW-1:0]       dt_flat;
    logic [`SSM_H*`SSM_DW-1:0]       da_flat;
    logic [`SSM_N*`SSM_DW-1:0]       b_flat;
    logic [`SSM_N*`SSM_DW-1:0]       c_flat;
    logic [`SSM_H*`SSM_DW-1:0]       d_flat;
    logic [NUM_Y*`SSM_DW-1:0]        x_flat;
    logic [NUM_ELEM*`SSM_DW-1:0]     h_prev_flat;
    logic [NUM_Y*`SSM_DW-1:0]        y_flat;
    logic [NUM_ELEM*`SSM_DW-1:0]     h_next_flat;
    logic                            done;
    logic [NUM_Y*`SSM_DW-1:0]        exp_y;
    logic [NUM_ELEM*`SSM_DW-1:0]     exp_h_next;
    q_t                              stim_mem [0:NUM_CASES*REC_WORDS-1];
    int                              cycle_cnt = 0;
    int                              tb_errors = 0;
    int                              mismatch_count;
    int                              proto_count;
    int                              done_count;

    // 4 ns period
    always #2 clk = ~clk;

    ssm_block_top UUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .dt_flat     (dt_flat),
        .da_flat     (da_flat),
        .b_flat      (b_flat),
        .c_flat      (c_flat),
        .d_flat      (d_flat),
        .x_flat      (x_flat),
        .h_prev_flat (h_prev_flat),
        .y_flat      (y_flat),
        .h_next_flat (h_next_flat),
        .done        (done)
    );

    tb_ssm_checker u_chk (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .done           (done),
        .y_flat         (y_flat),
        .h_next_flat    (h_next_flat),
        .exp_y          (exp_y),
        .exp_h_next     (exp_h_next),
        .mismatch_count (mismatch_count),
        .proto_count    (proto_count),
        .done_count     (done_count)
    );

    // closing counts, verdict, end of run
    task automatic close_run(input bit timed_out);
        int total;
        total = mismatch_count + proto_count + tb_errors;
        $display("errors: %0d mismatch, %0d protocol, %0d run; done pulses %0d of %0d",
                 mismatch_count, proto_count, tb_errors, done_count, NUM_CASES);
        if (total == 0 && !timed_out)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    // ============================================================
    // stimulus
    // ============================================================

    // unpack one record onto the input buses and expected values
    task automatic apply_case(input int k);
        int base;
        base = k * REC_WORDS;
        for (int i = 0; i < `SSM_H; i++) begin
            dt_flat[i*`SSM_DW +: `SSM_DW] = stim_mem[base + OFF_DT + i];
            da_flat[i*`SSM_DW +: `SSM_DW] = stim_mem[base + OFF_DA + i];
            d_flat[i*`SSM_DW +: `SSM_DW]  = stim_mem[base + OFF_D + i];
        end
        for (int i = 0; i < `SSM_N; i++) begin
            b_flat[i*`SSM_DW +: `SSM_DW] = stim_mem[base + OFF_B + i];
            c_flat[i*`SSM_DW +: `SSM_DW] = stim_mem[base + OFF_C + i];
        end
        for (int i = 0; i < NUM_Y; i++) begin
            x_flat[i*`SSM_DW +: `SSM_DW] = stim_mem[base + OFF_X + i];
            exp_y[i*`SSM_DW +: `SSM_DW]  = stim_mem[base + OFF_Y + i];
        end
        for (int i = 0; i < NUM_ELEM; i++) begin
            h_prev_flat[i*`SSM_DW +: `SSM_DW] = stim_mem[base + OFF_HP + i];
            exp_h_next[i*`SSM_DW +: `SSM_DW]  = stim_mem[base + OFF_HN + i];
        end
    endtask

    // garbage on the buses, latched copies must win
    task automatic scramble_inputs();
        dt_flat     = ~dt_flat;
        da_flat     = ~da_flat;
        b_flat      = ~b_flat;
        c_flat      = ~c_flat;
        d_flat      = ~d_flat;
        x_flat      = ~x_flat;
        h_prev_flat = ~h_prev_flat;
    endtask

    task automatic run_case(input int k, input bit poke);
        @(negedge clk);
        apply_case(k);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (poke) begin
            repeat (6) @(negedge clk);
            scramble_inputs();
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        // watchdog bounds this wait
        while (!done)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // ============================================================
    // watchdog
    // ============================================================

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            tb_errors++;
            close_run(1'b1);
        end
    end

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        dt_flat     = '0;
        da_flat     = '0;
        b_flat      = '0;
        c_flat      = '0;
        d_flat      = '0;
        x_flat      = '0;
        h_prev_flat = '0;
        exp_y       = '0;
        exp_h_next  = '0;
        $readmemh("ssm_block_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[NUM_CASES*REC_WORDS-1])) begin
            $display("stimulus file ssm_block_stimulus.txt is missing or too short");
            tb_errors++;
        end else begin
            repeat (8) @(negedge clk);
            rst = 1'b0;
            // idle window, outputs must read zero
            repeat (5) @(negedge clk);
            for (int k = 0; k < NUM_CASES; k++)
                run_case(k, k == POKE_CASE);
            // drain, catches late or extra done pulses
            repeat (NUM_ELEM + 8) @(negedge clk);
            if (done_count != NUM_CASES) begin
                $display("saw %0d done pulses for %0d cases", done_count, NUM_CASES);
                tb_errors++;
            end
        end
        close_run(1'b0);
    end

endmodule

`default_nettype wire

// File: tb_ssm_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ssm_defs.svh"

module tb_ssm_checker (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic                                   done,
    input  logic [`SSM_H*`SSM_P*`SSM_DW-1:0]       y_flat,
    input  logic [`SSM_H*`SSM_P*`SSM_N*`SSM_DW-1:0] h_next_flat,
    input  logic [`SSM_H*`SSM_P*`SSM_DW-1:0]       exp_y,
    input  logic [`SSM_H*`SSM_P*`SSM_N*`SSM_DW-1:0] exp_h_next,
    output int                                     mismatch_count,
    output int                                     proto_count,
    output int                                     done_count
);
    import ssm_num_pkg::*;

    localparam int NUM_Y    = `SSM_H * `SSM_P;
    localparam int NUM_ELEM = `SSM_H * `SSM_P * `SSM_N;
    // start edge to done edge
    localparam int LATENCY  = NUM_ELEM + 6;

    int   cyc         = 0;
    int   start_cyc   = 0;
    logic in_step     = 1'b0;  // mirrors the sequencer busy window
    logic seen_start  = 1'b0;
    logic have_result = 1'b0;
    logic done_prev   = 1'b0;
    logic [NUM_Y*`SSM_DW-1:0]    y_snap;
    logic [NUM_ELEM*`SSM_DW-1:0] hn_snap;
    int   mis_cnt     = 0;
    int   proto_cnt   = 0;
    int   done_cnt    = 0;

    assign mismatch_count = mis_cnt;
    assign proto_count    = proto_cnt;
    assign done_count     = done_cnt;

    // word by word, x or z counts as wrong
    task automatic compare_words(
        input string                       name,
        input logic [NUM_ELEM*`SSM_DW-1:0] got,
        input logic [NUM_ELEM*`SSM_DW-1:0] exp,
        input int                          count
    );
        q_t got_w;
        q_t exp_w;
        for (int i = 0; i < count; i++) begin
            got_w = got[i*`SSM_DW +: `SSM_DW];
            exp_w = exp[i*`SSM_DW +: `SSM_DW];
            if (got_w !== exp_w) begin
                $display("MISMATCH %s[%0d]: got 16'h%h, expected 16'h%h",
                         name, i, got_w, exp_w);
                mis_cnt++;
            end
        end
    endtask

    // ============================================================
    // start tracking on the rising edge
    // ============================================================

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            in_step <= 1'b0;
        end else begin
            cyc <= cyc + 1;
            if (done)
                in_step <= 1'b0;
            else if (start && !in_step) begin
                // accepted start, later starts ignored until done
                in_step    <= 1'b1;
                seen_start <= 1'b1;
                start_cyc  <= cyc + 1;
            end
        end
    end

    // ============================================================
    // output checks on the falling edge
    // ============================================================

    always @(negedge clk) begin
        if (!rst) begin
            // reset values hold until the first step
            if (!seen_start && (y_flat !== '0 || h_next_flat !== '0)) begin
                $display("outputs not zero after reset: y_flat %h h_next_flat %h",
                         y_flat, h_next_flat);
                proto_cnt++;
            end
            if (done) begin
                done_cnt++;
                if (done_prev) begin
                    $display("done stayed high for more than one cycle");
                    proto_cnt++;
                end
                if (!in_step) begin
                    $display("done pulsed with no accepted start");
                    proto_cnt++;
                end else if (cyc - start_cyc != LATENCY) begin
                    $display("done came %0d cycles after start, expected %0d",
                             cyc - start_cyc, LATENCY);
                    proto_cnt++;
                end
                compare_words("y_flat", y_flat, exp_y, NUM_Y);
                compare_words("h_next_flat", h_next_flat, exp_h_next, NUM_ELEM);
                y_snap      = y_flat;
                hn_snap     = h_next_flat;
                have_result = 1'b1;
            end else if (have_result && !in_step) begin
                // idle after done, results must hold
                if (y_flat !== y_snap || h_next_flat !== hn_snap) begin
                    $display("outputs changed after done with no new start");
                    proto_cnt++;
                end
            end
            done_prev = done;
        end
    end

endmodule

`default_nettype wire
